// File: design/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 32;
	localparam int REG_W = 4;
	localparam int ALU_OPC_W = 5;
	localparam int UC_ADDR_W = 7;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] reg_sel_t;
	typedef logic [ALU_OPC_W-1:0] alu_opc_t;
	typedef logic [UC_ADDR_W-1:0] uc_addr_t; // Class in 6:5, opcode in 4:0.

	typedef enum logic [1:0] {
		CLASS_ALU_REG = 2'd0,
		CLASS_ALU_IMM = 2'd1,
		CLASS_MEM     = 2'd2,
		CLASS_MISC    = 2'd3
	} instr_class_t;

	typedef enum logic [1:0] {
		IMM13 = 2'd0, // instr[24:12], sign extended.
		IMM24 = 2'd1, // instr[23:0] << 2, sign extended.
		HI16  = 2'd2,
		LO16  = 2'd3
	} imm_sel_t;

	localparam logic [4:0] OP_ADD = 5'd0;
	localparam logic [4:0] OP_SUB = 5'd1;
	localparam logic [4:0] OP_AND = 5'd2;
	localparam logic [4:0] OP_OR  = 5'd3;
	localparam logic [4:0] OP_XOR = 5'd4;
	localparam logic [4:0] OP_SHL = 5'd5;
	localparam logic [4:0] OP_SHR = 5'd6;
	localparam logic [4:0] OP_CMP = 5'd7;

	localparam logic [4:0] OP_LDR  = 5'd0;
	localparam logic [4:0] OP_STR  = 5'd1;
	localparam logic [4:0] OP_LDRB = 5'd2;
	localparam logic [4:0] OP_STRB = 5'd3;

	localparam logic [4:0] OP_MOVHI = 5'd0;
	localparam logic [4:0] OP_MOVLO = 5'd1;
	localparam logic [4:0] OP_CALL  = 5'd2;
	localparam logic [4:0] OP_SWI   = 5'd3;
	localparam logic [4:0] OP_RFE   = 5'd4;
	localparam logic [4:0] OP_BKP   = 5'd5;
	localparam logic [4:0] OP_CACHE = 5'd6;

	localparam logic [1:0] MEM_WIDTH_WORD = 2'd0;
	localparam logic [1:0] MEM_WIDTH_BYTE = 2'd2;

	localparam reg_sel_t LINK_REG = 4'd15;
	localparam word_t FETCH_START = 32'h0000_0000;

	typedef struct packed {
		logic legal;
		imm_sel_t imm_sel;
		alu_opc_t alu_opc;
		logic alu_op2_imm;
		logic update_rd;
		logic rd_is_lr;
		logic update_flags;
		logic mem_load;
		logic mem_store;
		logic [1:0] mem_width;
		logic is_call;
		logic is_swi;
		logic is_rfe;
		logic cache_instr;
	} ctrl_t;

	typedef struct packed {
		reg_sel_t ra_sel;
		reg_sel_t rb_sel;
		reg_sel_t rd_sel; // Before the link register override.
		word_t imm;
		logic bkpt;
	} fields_t;

	typedef struct packed {
		ctrl_t ctrl;
		reg_sel_t rd_sel;
		word_t imm;
		instr_class_t instr_class;
		word_t pc_plus_4;
		logic bkpt;
	} decoded_t;

endpackage

// File: design/fetch_wb.sv
`timescale 1ns/100ps

module fetch_wb import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output word_t wb_adr,
	input word_t wb_dat,
	input logic wb_ack,
	output word_t instr,
	output word_t pc_plus_4,
	output logic fetched
);

	typedef enum logic [1:0] {
		IDLE,
		BUS,
		HOLD
	} fetch_state_t;

	fetch_state_t state;
	word_t pc;
	logic launch;
	logic ack_edge;

	// A held word leaves and the next read starts in the same cycle.
	assign launch = (state == HOLD) && !stall;
	assign fetched = launch;

	assign wb_cyc = (state == BUS) || launch;
	assign wb_stb = wb_cyc;
	assign wb_we = 1'b0; // Read only port.
	assign wb_adr = pc;
	assign ack_edge = wb_cyc && wb_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			pc <= FETCH_START;
		end else begin
			case (state)
			IDLE: begin
				if (!stall)
					state <= BUS;
			end
			BUS: begin
				if (wb_ack)
					state <= HOLD;
			end
			HOLD: begin
				if (launch && !wb_ack)
					state <= BUS; // Zero wait ack stays in HOLD.
			end
			default: state <= IDLE;
			endcase

			if (ack_edge)
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (ack_edge) begin
			instr <= wb_dat;
			pc_plus_4 <= pc + 32'd4;
		end
	end

endmodule

// File: design/decode_control.sv
`timescale 1ns/100ps

module decode_control import cpu_pkg::*; (
	input word_t instr,
	output ctrl_t ctrl
);

	uc_addr_t uc_addr;
	instr_class_t cls;
	logic [4:0] opc;

	assign uc_addr = instr[31:25];
	assign cls = instr_class_t'(uc_addr[6:5]);
	assign opc = uc_addr[4:0];

	always_comb begin
		ctrl = '0;
		ctrl.imm_sel = IMM13;

		case (cls)
		CLASS_ALU_REG, CLASS_ALU_IMM: begin
			case (opc)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_CMP: begin
				ctrl.legal = 1'b1;
				ctrl.alu_opc = opc;
				ctrl.alu_op2_imm = (cls == CLASS_ALU_IMM);
				ctrl.update_rd = (opc != OP_CMP); // Compare only sets flags.
				ctrl.update_flags = (opc == OP_CMP);
			end
			default: ctrl.legal = 1'b0;
			endcase
		end
		CLASS_MEM: begin
			case (opc)
			OP_LDR, OP_LDRB, OP_STR, OP_STRB: begin
				ctrl.legal = 1'b1;
				ctrl.alu_opc = OP_ADD; // Base plus offset.
				ctrl.alu_op2_imm = 1'b1;
				ctrl.mem_load = (opc == OP_LDR) || (opc == OP_LDRB);
				ctrl.mem_store = (opc == OP_STR) || (opc == OP_STRB);
				ctrl.update_rd = ctrl.mem_load;
				if (opc == OP_LDRB || opc == OP_STRB)
					ctrl.mem_width = MEM_WIDTH_BYTE;
				else
					ctrl.mem_width = MEM_WIDTH_WORD;
			end
			default: ctrl.legal = 1'b0;
			endcase
		end
		CLASS_MISC: begin
			case (opc)
			OP_MOVHI, OP_MOVLO: begin
				ctrl.legal = 1'b1;
				ctrl.imm_sel = (opc == OP_MOVHI) ? HI16 : LO16;
				ctrl.alu_op2_imm = 1'b1;
				ctrl.update_rd = 1'b1;
			end
			OP_CALL: begin
				ctrl.legal = 1'b1;
				ctrl.imm_sel = IMM24;
				ctrl.alu_op2_imm = 1'b1;
				ctrl.is_call = 1'b1;
				ctrl.rd_is_lr = 1'b1; // Return address goes to r15.
				ctrl.update_rd = 1'b1;
			end
			OP_SWI: begin
				ctrl.legal = 1'b1;
				ctrl.is_swi = 1'b1;
			end
			OP_RFE: begin
				ctrl.legal = 1'b1;
				ctrl.is_rfe = 1'b1;
			end
			OP_BKP: ctrl.legal = 1'b1;
			OP_CACHE: begin
				ctrl.legal = 1'b1;
				ctrl.cache_instr = 1'b1;
			end
			default: ctrl.legal = 1'b0;
			endcase
		end
		default: ctrl.legal = 1'b0;
		endcase
	end

endmodule

// File: design/decode_fields.sv
`timescale 1ns/100ps

module decode_fields import cpu_pkg::*; (
	input word_t instr,
	output fields_t fields,
	input imm_sel_t imm_sel
);

	instr_class_t cls;
	word_t imm13;
	word_t imm24;
	word_t hi16;
	word_t lo16;

	assign cls = instr_class_t'(instr[31:30]);

	assign imm13 = {{19{instr[24]}}, instr[24:12]};
	assign imm24 = {{6{instr[23]}}, instr[23:0], 2'b00}; // Word offset.
	assign hi16 = {instr[25:10], 16'h0000};
	assign lo16 = {16'h0000, instr[25:10]};

	always_comb begin
		fields.ra_sel = instr[11:8];
		fields.rb_sel = instr[7:4];
		fields.rd_sel = instr[3:0];

		case (imm_sel)
		IMM13: fields.imm = imm13;
		IMM24: fields.imm = imm24;
		HI16: fields.imm = hi16;
		LO16: fields.imm = lo16;
		default: fields.imm = imm13;
		endcase

		fields.bkpt = (cls == CLASS_MISC) && (instr[29:25] == OP_BKP);
	end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic fetched,
	input ctrl_t ctrl,
	input fields_t fields,
	input word_t pc_plus_4,
	output decoded_t decoded,
	output logic dec_valid,
	output logic illegal,
	output logic exception_start,
	output logic bkpt_hit
);

	decoded_t bundle;

	// Class recovered from the controls, illegal words report ALU_REG.
	function automatic instr_class_t class_of(input ctrl_t c, input logic bkpt);
		if (!c.legal)
			return CLASS_ALU_REG;
		if (c.mem_load || c.mem_store)
			return CLASS_MEM;
		if (c.is_call || c.is_swi || c.is_rfe || c.cache_instr || bkpt ||
		    c.imm_sel == HI16 || c.imm_sel == LO16)
			return CLASS_MISC;
		if (c.alu_op2_imm)
			return CLASS_ALU_IMM;
		return CLASS_ALU_REG;
	endfunction

	always_comb begin
		bundle.ctrl = ctrl;
		bundle.rd_sel = ctrl.rd_is_lr ? LINK_REG : fields.rd_sel;
		bundle.imm = fields.imm;
		bundle.instr_class = class_of(ctrl, fields.bkpt);
		bundle.pc_plus_4 = pc_plus_4;
		bundle.bkpt = fields.bkpt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			decoded.ctrl.legal <= 1'b0;
			decoded.ctrl.update_rd <= 1'b0;
			decoded.ctrl.update_flags <= 1'b0;
			decoded.ctrl.mem_load <= 1'b0;
			decoded.ctrl.mem_store <= 1'b0;
			decoded.ctrl.is_call <= 1'b0;
			decoded.ctrl.is_swi <= 1'b0;
			decoded.ctrl.is_rfe <= 1'b0;
			decoded.ctrl.cache_instr <= 1'b0;
			dec_valid <= 1'b0;
			illegal <= 1'b0;
			exception_start <= 1'b0;
			bkpt_hit <= 1'b0;
		end else if (!stall) begin
			if (fetched)
				decoded <= bundle;
			dec_valid <= fetched && ctrl.legal;
			illegal <= fetched && !ctrl.legal;
			exception_start <= fetched && (!ctrl.legal || ctrl.is_swi);
			bkpt_hit <= fetched && fields.bkpt;
		end
	end

endmodule

// File: design/cpu_frontend.sv
`timescale 1ns/100ps

module cpu_frontend import cpu_pkg::*; (
	input logic clk,
	input logic rst,
	input logic stall,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output word_t wb_adr,
	input word_t wb_dat,
	input logic wb_ack,
	output decoded_t decoded,
	output logic dec_valid,
	output logic illegal,
	output logic exception_start,
	output logic bkpt_hit
);

	word_t instr;
	word_t pc_plus_4;
	logic fetched;
	ctrl_t ctrl;
	fields_t fields;

	fetch_wb u_fetch (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.instr(instr),
		.pc_plus_4(pc_plus_4),
		.fetched(fetched)
	);

	decode_control u_control (
		.instr(instr),
		.ctrl(ctrl)
	);

	decode_fields u_fields (
		.instr(instr),
		.fields(fields),
		.imm_sel(ctrl.imm_sel)
	);

	decode_stage u_stage (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.fetched(fetched),
		.ctrl(ctrl),
		.fields(fields),
		.pc_plus_4(pc_plus_4),
		.decoded(decoded),
		.dec_valid(dec_valid),
		.illegal(illegal),
		.exception_start(exception_start),
		.bkpt_hit(bkpt_hit)
	);

endmodule

// File: sim/tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend import cpu_pkg::*; ();

	localparam int N_SEQ = 8;
	localparam int N_ALU = 16;
	localparam int N_MEM = 8;
	localparam int N_EXC = 9;
	localparam int N_RAND = 24;
	localparam int TOTAL_INSTR = N_SEQ + N_ALU + N_MEM + N_EXC + N_RAND;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_INSTR;

	// One decoded word as the outside sees it.
	typedef struct packed {
		decoded_t dec;
		logic valid;
		logic ill;
		logic exc;
		logic bkpt;
	} obs_t;

	logic clk;
	logic rst = 1'b1;
	logic stall = 1'b0;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	word_t wb_adr;
	word_t wb_dat = '0;
	logic wb_ack = 1'b0;
	decoded_t decoded;
	logic dec_valid;
	logic illegal;
	logic exception_start;
	logic bkpt_hit;

	word_t prog [0:63];
	int prog_len = 0;
	logic stall_on = 1'b0;
	logic delay_on = 1'b0;
	logic [1:0] wait_cnt = 2'd0;
	logic [1:0] rnd_bits;
	logic [31:0] lfsr = 32'hfbfa;
	logic [31:0] prog_lfsr = 32'hfbfa;
	int cycles = 0;
	int monitor_errors = 0;
	int monitor_base;
	int obs_base;
	int ack_base;
	int test_errors;
	int total_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	obs_t obs_q[$];
	int valid_cyc_q[$];
	int ack_cyc_q[$];
	word_t ack_adr_q[$];
	obs_t cur_obs;
	obs_t last_obs = '0;
	logic stall_seen = 1'b0;

	assign cur_obs = {decoded, dec_valid, illegal, exception_start, bkpt_hit};

	cpu_frontend UUT (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.decoded(decoded),
		.dec_valid(dec_valid),
		.illegal(illegal),
		.exception_start(exception_start),
		.bkpt_hit(bkpt_hit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	task automatic take_bits(input int n, output logic [1:0] v);
		v = 2'b00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[0], lfsr[0]};
		end
	endtask

	function automatic word_t enc(input instr_class_t c, input logic [4:0] op,
			input logic [24:0] rest);
		return {c, op, rest};
	endfunction

	// Words past the end of the program.
	function automatic word_t fill_word(input word_t adr);
		return adr ^ 32'h1357_9bdf;
	endfunction

	// Expected output for one word from the instruction set rules.
	function automatic obs_t ref_decode(input word_t w, input word_t pc4);
		obs_t e;
		ctrl_t c;
		logic [1:0] cls;
		logic [4:0] op;
		cls = w[31:30];
		op = w[29:25];
		c = '0;
		c.imm_sel = IMM13;
		c.legal = 1'b1;
		if (cls == 2'd0 || cls == 2'd1) begin
			if (op <= OP_CMP) begin
				c.alu_opc = op;
				c.alu_op2_imm = (cls == 2'd1);
				c.update_rd = (op != OP_CMP);
				c.update_flags = (op == OP_CMP);
			end else begin
				c.legal = 1'b0;
			end
		end else if (cls == 2'd2) begin
			if (op <= OP_STRB) begin
				c.alu_op2_imm = 1'b1;
				c.mem_load = !op[0]; // Odd codes store.
				c.mem_store = op[0];
				c.update_rd = !op[0];
				c.mem_width = op[1] ? MEM_WIDTH_BYTE : MEM_WIDTH_WORD;
			end else begin
				c.legal = 1'b0;
			end
		end else begin
			case (op)
			OP_MOVHI: begin
				c.imm_sel = HI16;
				c.alu_op2_imm = 1'b1;
				c.update_rd = 1'b1;
			end
			OP_MOVLO: begin
				c.imm_sel = LO16;
				c.alu_op2_imm = 1'b1;
				c.update_rd = 1'b1;
			end
			OP_CALL: begin
				c.imm_sel = IMM24;
				c.alu_op2_imm = 1'b1;
				c.is_call = 1'b1;
				c.rd_is_lr = 1'b1;
				c.update_rd = 1'b1;
			end
			OP_SWI: c.is_swi = 1'b1;
			OP_RFE: c.is_rfe = 1'b1;
			OP_BKP: c.legal = 1'b1;
			OP_CACHE: c.cache_instr = 1'b1;
			default: c.legal = 1'b0;
			endcase
		end
		e = '0;
		e.dec.ctrl = c;
		e.dec.rd_sel = c.rd_is_lr ? 4'd15 : w[3:0];
		case (c.imm_sel)
		IMM13: e.dec.imm = 32'($signed(w[24:12]));
		IMM24: e.dec.imm = 32'($signed(w[23:0])) << 2;
		HI16: e.dec.imm = word_t'(w[25:10]) << 16;
		default: e.dec.imm = word_t'(w[25:10]);
		endcase
		e.dec.instr_class = instr_class_t'(cls);
		e.dec.pc_plus_4 = pc4;
		e.dec.bkpt = (cls == 2'd3) && (op == OP_BKP);
		e.valid = c.legal;
		e.ill = !c.legal;
		e.exc = !c.legal || c.is_swi;
		e.bkpt = e.dec.bkpt;
		return e;
	endfunction

	// Instruction memory slave and stall source.
	always @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			wait_cnt <= 2'd0;
			stall <= 1'b0;
		end else begin
			if (stall_on) begin
				take_bits(1, rnd_bits);
				stall <= rnd_bits[0];
			end else begin
				stall <= 1'b0;
			end
			if (wb_ack) begin
				wb_ack <= 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (wait_cnt == 2'd0) begin
					wb_ack <= 1'b1;
					if (wb_adr < word_t'(prog_len * 4))
						wb_dat <= prog[wb_adr[7:2]];
					else
						wb_dat <= fill_word(wb_adr);
					if (delay_on) begin
						take_bits(2, rnd_bits);
						wait_cnt <= rnd_bits;
					end else begin
						wait_cnt <= 2'd0;
					end
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

	// Collects acks and consumed words and watches the bus and the held output.
	always @(posedge clk) begin
		if (!rst) begin
			if (wb_cyc && wb_stb && wb_ack) begin
				ack_cyc_q.push_back(cycles);
				ack_adr_q.push_back(wb_adr);
			end
			if (wb_we !== 1'b0 || wb_stb !== wb_cyc) begin
				monitor_errors <= monitor_errors + 1;
				$display("Bus read wrong, write enable high or strobe apart from cycle, cycle %0d",
					cycles);
			end
			if (stall_seen && cur_obs !== last_obs) begin
				monitor_errors <= monitor_errors + 1;
				$display("Decode output changed while stall was high, cycle %0d", cycles);
			end
			if ((dec_valid || illegal) && !stall) begin
				obs_q.push_back(cur_obs);
				valid_cyc_q.push_back(cycles);
			end
		end
		last_obs <= cur_obs;
		stall_seen <= stall && !rst;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, decode output stopped arriving", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic hold_reset(input logic use_stall, input logic use_delay);
		@(posedge clk);
		rst <= 1'b1;
		stall_on <= use_stall;
		delay_on <= use_delay;
	endtask

	task automatic release_reset(input int n);
		prog_len = n;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		obs_base = obs_q.size();
		ack_base = ack_cyc_q.size();
		monitor_base = monitor_errors;
		test_errors = 0;
	endtask

	task automatic check_program(input string name, input int n);
		obs_t exp;
		obs_t act;
		while (obs_q.size() < obs_base + n)
			@(negedge clk);
		for (int i = 0; i < n; i++) begin
			exp = ref_decode(prog[i], 32'(4 * i + 4));
			act = obs_q[obs_base + i];
			if (exp.valid && act !== exp) begin
				test_errors++;
				$display("ERR %s word %0d: expected %h, actual %h", name, i, exp, act);
			end
			if (!exp.valid && {act.valid, act.ill, act.exc, act.bkpt, act.dec.pc_plus_4} !==
					{exp.valid, exp.ill, exp.exc, exp.bkpt, exp.dec.pc_plus_4}) begin
				test_errors++;
				$display("ERR %s word %0d: expected %h, actual %h", name, i, exp, act);
			end
		end
	endtask

	task automatic finish_test(input string name);
		test_errors += monitor_errors - monitor_base;
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
	endtask

	task automatic fetch_sequence();
		int lat;
		hold_reset(1'b0, 1'b0);
		for (int k = 0; k < N_SEQ; k++)
			prog[k] = enc(CLASS_ALU_IMM, OP_ADD, {13'(k * 3), 4'(k), 4'(k + 1), 4'(k + 2)});
		release_reset(N_SEQ);
		check_program("sequence", N_SEQ);
		for (int i = 0; i < N_SEQ; i++) begin
			lat = valid_cyc_q[obs_base + i] - ack_cyc_q[ack_base + i];
			if (ack_adr_q[ack_base + i] !== 32'(4 * i)) begin
				test_errors++;
				$display("ERR sequence address %0d: expected %h, actual %h", i, 32'(4 * i),
					ack_adr_q[ack_base + i]);
			end
			if (lat != 2) begin
				test_errors++;
				$display("ERR sequence latency %0d: expected 2, actual %0d", i, lat);
			end
		end
		finish_test("sequence");
	endtask

	task automatic alu_opcodes();
		logic [12:0] imm;
		hold_reset(1'b0, 1'b1);
		for (int k = 0; k < 8; k++) begin
			imm = (k % 2 == 0) ? 13'(k * 37) : (13'h1000 | 13'(k)); // Odd ones negative.
			prog[k] = enc(CLASS_ALU_REG, 5'(k), {13'h0, 4'(k), 4'(15 - k), 4'(k + 3)});
			prog[k + 8] = enc(CLASS_ALU_IMM, 5'(k), {imm, 4'(k + 1), 4'(k), 4'(14 - k)});
		end
		release_reset(N_ALU);
		check_program("alu", N_ALU);
		finish_test("alu");
	endtask

	task automatic mem_and_call();
		hold_reset(1'b0, 1'b1);
		prog[0] = enc(CLASS_MEM, OP_LDR, {13'h0040, 4'd2, 4'd0, 4'd5});
		prog[1] = enc(CLASS_MEM, OP_STR, {13'h1ffc, 4'd3, 4'd6, 4'd0});
		prog[2] = enc(CLASS_MEM, OP_LDRB, {13'h0001, 4'd4, 4'd0, 4'd7});
		prog[3] = enc(CLASS_MEM, OP_STRB, {13'h1000, 4'd9, 4'd8, 4'd1});
		prog[4] = enc(CLASS_MISC, OP_CALL, {1'b0, 24'h00_0123});
		prog[5] = enc(CLASS_MISC, OP_CALL, {1'b1, 24'hff_fff0});
		prog[6] = enc(CLASS_MISC, OP_MOVHI, 25'h1ab_cd55);
		prog[7] = enc(CLASS_MISC, OP_MOVLO, 25'h0f0_f0f3);
		release_reset(N_MEM);
		check_program("mem_call", N_MEM);
		finish_test("mem_call");
	endtask

	task automatic exception_codes();
		hold_reset(1'b0, 1'b1);
		prog[0] = enc(CLASS_ALU_REG, 5'd8, 25'h000_0000);
		prog[1] = enc(CLASS_ALU_IMM, 5'd31, 25'h000_1234);
		prog[2] = enc(CLASS_MEM, 5'd4, 25'h0ab_cdef);
		prog[3] = enc(CLASS_MISC, 5'd7, 25'h155_5555);
		prog[4] = enc(CLASS_MISC, 5'd20, 25'h0aa_aaaa);
		prog[5] = enc(CLASS_MISC, OP_SWI, 25'h000_0042);
		prog[6] = enc(CLASS_MISC, OP_RFE, 25'h000_0000);
		prog[7] = enc(CLASS_MISC, OP_BKP, 25'h000_0007);
		prog[8] = enc(CLASS_MISC, OP_CACHE, 25'h000_0310);
		release_reset(N_EXC);
		check_program("exceptions", N_EXC);
		finish_test("exceptions");
	endtask

	task automatic random_stall();
		word_t w;
		hold_reset(1'b1, 1'b1);
		for (int k = 0; k < N_RAND; k++) begin
			w = '0;
			for (int b = 0; b < 30; b++) begin
				prog_lfsr = lfsr_next(prog_lfsr);
				w = {w[30:0], prog_lfsr[0]};
			end
			prog[k] = {w[29:28], 2'b00, w[27:0]}; // Opcodes 0 to 7 in every class.
		end
		release_reset(N_RAND);
		check_program("random_stall", N_RAND);
		finish_test("random_stall");
	endtask

	initial begin
		fetch_sequence();
		alu_opcodes();
		mem_and_call();
		exception_codes();
		random_stall();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: list.f
design/cpu_pkg.sv
design/fetch_wb.sv
design/decode_control.sv
design/decode_fields.sv
design/decode_stage.sv
design/cpu_frontend.sv
sim/tb_frontend.sv

// File: run.sh
#!/bin/bash
# Builds the front end testbench with Verilator and runs it into sim.log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_frontend -f list.f -Mdir obj_dir -o sim_frontend

./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
